//--- Bender.yml
package:
  name: snes_mem

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/snes_mem_pkg.sv
      - rtl/rom_loader.sv
      - rtl/cpu_port_req.sv
      - rtl/rv_bridge.sv
      - rtl/word_mem.sv
      - rtl/snes_mem_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/tb_clock.sv
      - dv/snes_mem_tb.sv

//--- dv/snes_mem_tb.sv
// Byte model check of the memory front end. Console reads peek at the DUT port toggles for data valid
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_consts.svh"

module snes_mem_tb
    import snes_mem_pkg::*;
;

    localparam int N_LOAD = 64;
    localparam int N_ROM  = 16;
    localparam int N_WRAM = 8;
    localparam int N_RV   = 8;
    // Reset, two loads, all ROM, WRAM and soft core steps
    localparam int STEPS  = 10 + 2 * N_LOAD + 7 * N_ROM + 3 * N_WRAM + N_RV + 6;
    localparam int LIMIT  = 20 * STEPS;

    logic        mclk;
    logic        resetn;
    logic        loading;
    logic        load_valid;
    logic [7:0]  load_data;
    cpu_bus_t    cpu_bus;
    logic        rv_valid;
    rv_req_t     rv_cmd;
    logic [15:0] rom_q;
    logic [7:0]  wram_q;
    logic        rv_ready;
    logic [31:0] rv_rdata;
    logic        loaded;
    logic        enable;

    logic [7:0]  model [0:(1 << `BYTE_ADDR_W) - 1];
    logic [10:0] wram_list [N_WRAM];
    int          errors;
    int          checks;
    int          tests;
    int          base_errors;
    int          cycles;

    tb_clock #(.RESET_CYCLES(10)) i_tb_clock (.mclk(mclk), .resetn(resetn));

    snes_mem_top i_snes_mem_top (
        .mclk       (mclk),
        .resetn     (resetn),
        .loading    (loading),
        .load_valid (load_valid),
        .load_data  (load_data),
        .cpu_bus    (cpu_bus),
        .rv_valid   (rv_valid),
        .rv_cmd     (rv_cmd),
        .rom_q      (rom_q),
        .wram_q     (wram_q),
        .rv_ready   (rv_ready),
        .rv_rdata   (rv_rdata),
        .loaded     (loaded),
        .enable     (enable)
    );

    a_ready_single: assert property (@(posedge mclk) disable iff (!resetn)
        rv_ready |=> !rv_ready)
        else begin
            $display("rv_ready stayed high for two cycles");
            errors++;
        end
    a_ready_after_valid: assert property (@(posedge mclk) disable iff (!resetn)
        rv_ready |-> $past(rv_valid))
        else begin
            $display("rv_ready came without a soft core request");
            errors++;
        end
    a_loaded_set: assert property (@(posedge mclk) disable iff (!resetn)
        $fell(loading) |=> loaded)
        else begin
            $display("loaded did not rise one cycle after loading fell");
            errors++;
        end
    a_loaded_clear: assert property (@(posedge mclk) disable iff (!resetn)
        $rose(loading) |=> !loaded)
        else begin
            $display("loaded was not cleared when a load started");
            errors++;
        end
    a_enable_follow: assert property (@(posedge mclk) disable iff (!resetn)
        $rose(loaded) |=> enable)
        else begin
            $display("enable did not follow loaded");
            errors++;
        end

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %s finished, %0d errors", name, errors - base_errors);
        base_errors = errors;
    endtask

    // Console request toggles and its acknowledge catches up
    task automatic console_wait(input string name);
        logic old_req;
        logic served;
        int   n;
        old_req = i_snes_mem_top.cpu_req;
        served  = 1'b0;
        n       = 0;
        while (!served && n < 16) begin
            @(negedge mclk);
            n++;
            served = (i_snes_mem_top.cpu_req != old_req)
                   && (i_snes_mem_top.cpu_req == i_snes_mem_top.cpu_ack);
        end
        if (!served) begin
            $display("Console request in %s was never acknowledged", name);
            errors++;
        end
    endtask

    task automatic stream_rom(input string name, input int count);
        logic [7:0] b;
        loading = 1'b1;
        @(negedge mclk);
        check_equal(name, 32'h0, {31'h0, loaded});
        for (int i = 0; i < count; i++) begin
            b = 8'($urandom);
            model[i]   = b;
            load_valid = 1'b1;
            load_data  = b;
            @(negedge mclk);
            load_valid = 1'b0;
            @(negedge mclk);
        end
        repeat (4) @(negedge mclk);   // Last word write drains
        loading = 1'b0;
        repeat (2) @(negedge mclk);
        check_equal(name, 32'h1, {31'h0, loaded});
        check_equal(name, 32'h1, {31'h0, enable});
    endtask

    task automatic read_rom(input string name, input logic [13:0] addr);
        logic [15:0] exp;
        exp = addr[0] ? {model[addr - 1], model[addr]} : {model[addr + 1], model[addr]};
        cpu_bus.rom_addr = addr;
        cpu_bus.rom_ce_n = 1'b0;
        console_wait(name);
        check_equal(name, {16'h0, exp}, {16'h0, rom_q});
        cpu_bus.rom_ce_n = 1'b1;
    endtask

    task automatic write_wram(input string name, input logic [10:0] addr, input logic [7:0] d);
        cpu_bus.wram_addr = addr;
        cpu_bus.wram_d    = d;
        cpu_bus.wram_ce_n = 1'b0;
        cpu_bus.wram_we_n = 1'b0;
        console_wait(name);
        model[`WRAM_BASE + addr] = d;
        cpu_bus.wram_ce_n = 1'b1;
        cpu_bus.wram_we_n = 1'b1;
        @(negedge mclk);              // Strobe seen high before the next one
    endtask

    task automatic read_wram(input string name, input logic [10:0] addr);
        cpu_bus.wram_addr = addr;
        cpu_bus.wram_ce_n = 1'b0;
        cpu_bus.wram_rd_n = 1'b0;
        console_wait(name);
        check_equal(name, {24'h0, model[`WRAM_BASE + addr]}, {24'h0, wram_q});
        cpu_bus.wram_ce_n = 1'b1;
        cpu_bus.wram_rd_n = 1'b1;
        @(negedge mclk);
    endtask

    // Zero strobes read and compare while others update the model bytes
    task automatic rv_access(input string name, input logic [13:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb);
        logic [31:0] exp;
        int          n;
        exp      = {model[addr + 3], model[addr + 2], model[addr + 1], model[addr]};
        rv_cmd   = '{addr: addr, wdata: wdata, wstrb: wstrb};
        rv_valid = 1'b1;
        n        = 0;
        do begin
            @(negedge mclk);
            n++;
        end while (!rv_ready && n < 32);
        if (!rv_ready) begin
            $display("Soft core access in %s never got rv_ready", name);
            errors++;
        end else if (wstrb == 4'h0) begin
            check_equal(name, exp, rv_rdata);
        end
        for (int i = 0; i < 4; i++)
            if (wstrb[i])
                model[addr + i] = wdata[8 * i +: 8];
        rv_valid = 1'b0;
        @(negedge mclk);
    endtask

    initial begin
        while (cycles < LIMIT) @(posedge mclk) cycles++;
        $display("Timeout after %0d cycles, run did not finish", cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        errors      = 0;
        checks      = 0;
        tests       = 0;
        base_errors = 0;
        cycles      = 0;
        void'($urandom(32'ha3dd));
        loading     = 1'b0;
        load_valid  = 1'b0;
        load_data   = '0;
        rv_valid    = 1'b0;
        rv_cmd      = '0;
        cpu_bus     = '{rom_addr: '0, rom_ce_n: 1'b1, wram_addr: '0, wram_ce_n: 1'b1,
                        wram_rd_n: 1'b1, wram_we_n: 1'b1, wram_d: '0};
        @(posedge resetn);
        @(negedge mclk);

        check_equal("reset", 32'h0, {29'h0, loaded, enable, rv_ready});
        end_test("reset");

        stream_rom("load_rom", N_LOAD);
        for (int i = 0; i < N_ROM; i++)
            read_rom("load_rom", 14'(i));       // Even and odd byte addresses
        end_test("load_rom");

        for (int i = 0; i < N_WRAM; i++) begin
            wram_list[i] = 11'(N_ROM + $urandom % N_ROM);  // Same offsets as the ROM words below
            write_wram("wram", wram_list[i], 8'($urandom));
        end
        for (int i = 0; i < N_WRAM; i++)
            read_wram("wram", wram_list[i]);
        for (int i = 0; i < N_ROM; i++)
            read_rom("wram", 14'(N_ROM + i));   // ROM area untouched
        end_test("wram");

        rv_access("soft_core", 14'h80, $urandom, 4'hf);
        rv_access("soft_core", 14'h80, 32'h0, 4'h0);
        rv_access("soft_core", 14'h80, $urandom, 4'hc);
        rv_access("soft_core", 14'h80, 32'h0, 4'h0);
        rv_access("soft_core", 14'h80, $urandom, 4'h3);
        rv_access("soft_core", 14'h80, 32'h0, 4'h0);
        end_test("soft_core");

        fork
            begin
                for (int i = 0; i < N_ROM; i++)
                    read_rom("concurrent", 14'(2 * N_ROM + i));
                for (int i = 0; i < N_WRAM; i++)
                    read_wram("concurrent", wram_list[i]);
            end
            begin
                // Write then read back each word away from the console reads
                for (int k = 0; k < N_RV; k++)
                    rv_access("concurrent", 14'(256 + 4 * (k / 2)), $urandom,
                              k[0] ? 4'h0 : 4'hf);
            end
        join
        end_test("concurrent");

        stream_rom("reload", N_LOAD);
        for (int i = 0; i < N_LOAD; i++)
            read_rom("reload", 14'(i));
        end_test("reload");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
// Free running 10 ns clock. resetn is held low for RESET_CYCLES and released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic mclk,
    output logic resetn
);

    initial begin
        mclk = 1'b0;
        forever #5 mclk = ~mclk;
    end

    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge mclk);
        @(negedge mclk);
        resetn = 1'b1;     // Released away from the sampling edge
    end

endmodule

`default_nettype wire

//--- rtl/cpu_port_req.sv
// Console port requests. Only one request may be in flight and ROM and WRAM triggers must not coincide
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_consts.svh"

module cpu_port_req
    import snes_mem_pkg::*;
(
    input  logic        mclk,
    input  logic        resetn,
    input  logic        loading,
    input  load_wr_t    load_wr,
    input  cpu_bus_t    cpu_bus,
    input  logic        mem_ack,
    input  logic [15:0] mem_rdata,
    output logic        mem_req,
    output mem_req_t    mem_cmd,
    output logic [15:0] rom_q,
    output logic [7:0]  wram_q
);

    logic                    wram_rd;
    logic                    wram_wr;
    logic                    wram_rd_r;
    logic                    wram_wr_r;
    logic                    load_go;
    logic                    wram_go;
    logic                    rom_go;
    logic                    rom_sd_vld;
    logic [`BYTE_ADDR_W-1:0] rom_addr_sd;
    logic [`WRAM_ADDR_W-1:0] wram_addr_sd;
    logic [`BYTE_ADDR_W-1:0] wram_byte_addr;
    logic                    last_we;
    logic                    last_wram;
    logic                    rom_odd;
    logic                    wram_hi;
    logic                    rom_live;
    logic                    wram_live;
    logic [15:0]             rom_view;
    logic [15:0]             rom_hold;
    logic [7:0]              wram_view;
    logic [7:0]              wram_hold;

    assign wram_rd = ~cpu_bus.wram_ce_n & ~cpu_bus.wram_rd_n;
    assign wram_wr = ~cpu_bus.wram_ce_n & ~cpu_bus.wram_we_n;
    assign wram_byte_addr = `WRAM_BASE
                          | {{(`BYTE_ADDR_W - `WRAM_ADDR_W){1'b0}}, cpu_bus.wram_addr};

    assign load_go = loading & load_wr.valid;
    assign wram_go = ~loading
                   & ((wram_rd & (~wram_rd_r
                                  | cpu_bus.wram_addr[`WRAM_ADDR_W-1:1]
                                    != wram_addr_sd[`WRAM_ADDR_W-1:1]))
                      | (wram_wr & ~wram_wr_r));
    assign rom_go  = ~loading & ~cpu_bus.rom_ce_n
                   & (~rom_sd_vld | (cpu_bus.rom_addr != rom_addr_sd));

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            mem_req      <= 1'b0;
            wram_rd_r    <= 1'b0;
            wram_wr_r    <= 1'b0;
            rom_sd_vld   <= 1'b0;
            rom_addr_sd  <= '0;
            wram_addr_sd <= '0;
            last_we      <= 1'b1;
            last_wram    <= 1'b0;
            rom_odd      <= 1'b0;
            wram_hi      <= 1'b0;
        end else begin
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;
            if (load_go) begin
                mem_req    <= ~mem_req;
                last_we    <= 1'b1;
                last_wram  <= 1'b0;
                rom_sd_vld <= 1'b0;     // New contents, next ROM read must go out
            end else if (wram_go) begin
                mem_req      <= ~mem_req;
                last_we      <= wram_wr;
                last_wram    <= 1'b1;
                wram_addr_sd <= cpu_bus.wram_addr;
                wram_hi      <= cpu_bus.wram_addr[0];
            end else if (rom_go) begin
                mem_req     <= ~mem_req;
                last_we     <= 1'b0;
                last_wram   <= 1'b0;
                rom_sd_vld  <= 1'b1;
                rom_addr_sd <= cpu_bus.rom_addr;
                rom_odd     <= cpu_bus.rom_addr[0];
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (load_go)
            mem_cmd <= '{addr: load_wr.addr[`BYTE_ADDR_W-1:1], we: 1'b1,
                         be: 2'b11, wdata: load_wr.data};
        else if (wram_go)
            mem_cmd <= '{addr: wram_byte_addr[`BYTE_ADDR_W-1:1], we: wram_wr,
                         be: {cpu_bus.wram_addr[0], ~cpu_bus.wram_addr[0]},
                         wdata: {cpu_bus.wram_d, cpu_bus.wram_d}};
        else if (rom_go)
            mem_cmd <= '{addr: cpu_bus.rom_addr[`BYTE_ADDR_W-1:1], we: 1'b0,
                         be: 2'b11, wdata: '0};
    end

    // Byte steering on the word just read
    assign rom_view  = rom_odd ? {mem_rdata[7:0], mem_rdata[15:8]} : mem_rdata;
    assign wram_view = wram_hi ? mem_rdata[15:8] : mem_rdata[7:0];

    // Live once the last read of that kind is acknowledged
    assign rom_live  = (mem_req == mem_ack) & ~last_we & ~last_wram;
    assign wram_live = (mem_req == mem_ack) & ~last_we & last_wram;

    always_ff @(posedge mclk) begin
        if (rom_live)
            rom_hold <= rom_view;
        if (wram_live)
            wram_hold <= wram_view;
    end

    assign rom_q  = rom_live ? rom_view : rom_hold;
    assign wram_q = wram_live ? wram_view : wram_hold;

    a_no_overrun: assert property (@(posedge mclk) disable iff (!resetn)
        (mem_req != mem_ack) |=> $stable(mem_req));

endmodule

`default_nettype wire

//--- rtl/rom_loader.sv
// ROM loader byte pairing. Loading always starts at byte 0 and the stream has no back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_consts.svh"

module rom_loader
    import snes_mem_pkg::*;
(
    input  logic       mclk,
    input  logic       resetn,
    input  logic       loading,
    input  logic       load_valid,
    input  logic [7:0] load_data,
    output load_wr_t   load_wr,
    output logic       loaded,
    output logic       enable
);

    logic                    loading_r;
    logic                    start;
    logic [`BYTE_ADDR_W-1:0] byte_addr;
    logic [`BYTE_ADDR_W-1:0] cur_addr;
    logic [7:0]              even_byte;
    logic                    wr_valid;
    logic [`BYTE_ADDR_W-1:0] wr_addr;
    logic [15:0]             wr_data;

    assign start    = loading & ~loading_r;
    assign cur_addr = start ? '0 : byte_addr;   // First byte may come with the rising edge
    assign load_wr  = '{valid: wr_valid, addr: wr_addr, data: wr_data};

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            byte_addr <= '0;
            wr_valid  <= 1'b0;
            loaded    <= 1'b0;
            enable    <= 1'b0;
        end else begin
            loading_r <= loading;
            enable    <= loaded;
            wr_valid  <= load_valid & cur_addr[0];  // Word goes out on the odd byte
            if (load_valid)
                byte_addr <= cur_addr + 1'b1;
            else if (start)
                byte_addr <= '0;
            if (start)
                loaded <= 1'b0;
            else if (~loading & loading_r)
                loaded <= 1'b1;
        end
    end

    // Even byte waits in the low half for its partner
    always_ff @(posedge mclk) begin
        if (load_valid) begin
            if (cur_addr[0]) begin
                wr_addr <= cur_addr;
                wr_data <= {load_data, even_byte};
            end else begin
                even_byte <= load_data;
            end
        end
    end

    a_valid_in_load: assert property (@(posedge mclk) disable iff (!resetn)
        load_valid |-> loading);

endmodule

`default_nettype wire

//--- rtl/rv_bridge.sv
// Soft core to 16-bit memory bridge. One access at a time, started on the rising edge of rv_valid
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_consts.svh"

module rv_bridge
    import snes_mem_pkg::*;
(
    input  logic        mclk,
    input  logic        resetn,
    input  logic        rv_valid,
    input  rv_req_t     rv_cmd,
    input  logic        mem_ack,
    input  logic [15:0] mem_rdata,
    output logic        rv_ready,
    output logic [31:0] rv_rdata,
    output logic        mem_req,
    output mem_req_t    mem_cmd
);

    typedef enum logic [2:0] {
        RV_IDLE,
        RV_WAIT_LO,
        RV_DATA_LO,
        RV_WAIT_HI,
        RV_DATA_HI
    } rv_state_t;

    rv_state_t   state;
    logic        rv_valid_r;
    logic        new_req;
    logic        rv_word;       // Which half is on the memory port
    logic [1:0]  rv_ds;
    logic [15:0] dout_lo;
    logic        wr;
    logic        start;
    logic        acked;

    assign wr    = |rv_cmd.wstrb;
    assign start = rv_valid & ~rv_valid_r;
    assign acked = mem_req == mem_ack;

    assign mem_cmd = '{addr: {rv_cmd.addr[`BYTE_ADDR_W-1:2], rv_word}, we: wr, be: rv_ds,
                       wdata: rv_word ? rv_cmd.wdata[31:16] : rv_cmd.wdata[15:0]};
    assign rv_rdata = {mem_rdata, dout_lo};  // High half still on the port at rv_ready

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state      <= RV_IDLE;
            rv_ready   <= 1'b0;
            mem_req    <= 1'b0;
            rv_valid_r <= 1'b0;
            new_req    <= 1'b0;
            rv_word    <= 1'b0;
            rv_ds      <= 2'b11;
        end else begin
            rv_valid_r <= rv_valid;
            rv_ready   <= 1'b0;
            if (start)
                new_req <= 1'b1;
            case (state)
                RV_IDLE: if (start || new_req) begin
                    new_req <= 1'b0;
                    mem_req <= ~mem_req;
                    if (wr && rv_cmd.wstrb[1:0] == 2'b00) begin
                        rv_word <= 1'b1;            // Upper half only
                        rv_ds   <= rv_cmd.wstrb[3:2];
                        state   <= RV_WAIT_HI;
                    end else begin
                        rv_word <= 1'b0;
                        rv_ds   <= wr ? rv_cmd.wstrb[1:0] : 2'b11;
                        state   <= RV_WAIT_LO;
                    end
                end
                RV_WAIT_LO: if (acked) begin
                    if (wr && rv_cmd.wstrb[3:2] == 2'b00) begin
                        rv_ready <= 1'b1;           // Lower half only, done
                        state    <= RV_IDLE;
                    end else begin
                        mem_req <= ~mem_req;
                        rv_word <= 1'b1;
                        rv_ds   <= wr ? rv_cmd.wstrb[3:2] : 2'b11;
                        state   <= wr ? RV_WAIT_HI : RV_DATA_LO;
                    end
                end
                RV_DATA_LO: state <= RV_WAIT_HI;
                RV_WAIT_HI: if (acked) begin
                    if (wr) begin
                        rv_ready <= 1'b1;
                        state    <= RV_IDLE;
                    end else begin
                        state <= RV_DATA_HI;
                    end
                end
                RV_DATA_HI: begin
                    rv_ready <= 1'b1;
                    state    <= RV_IDLE;
                end
                default: state <= RV_IDLE;
            endcase
        end
    end

    // Low half is still held while the high request is being served
    always_ff @(posedge mclk) begin
        if (state == RV_DATA_LO)
            dout_lo <= mem_rdata;
    end

    a_ready_pulse: assert property (@(posedge mclk) disable iff (!resetn)
        rv_ready |=> !rv_ready);

endmodule

`default_nettype wire

//--- rtl/snes_mem_consts.svh
// Memory geometry macros. WRAM_BASE must be aligned to the window size and track BYTE_ADDR_W
`ifndef SNES_MEM_CONSTS_SVH
`define SNES_MEM_CONSTS_SVH

// Shared word memory, byte addressed
`define BYTE_ADDR_W 14

// 16-bit words
`define WORD_ADDR_W (`BYTE_ADDR_W - 1)

// Work RAM is a 2 KB window
`define WRAM_ADDR_W 11

// Top 2 KB of a 16 KB space, clear of the ROM area at byte 0
`define WRAM_BASE 14'h3800

`endif

//--- rtl/snes_mem_pkg.sv
// Request and bus structs for the memory front end. Field widths come from snes_mem_consts.svh
`default_nettype none

`include "snes_mem_consts.svh"

package snes_mem_pkg;

    // One access to the 16-bit word memory
    typedef struct packed {
        logic [`WORD_ADDR_W-1:0] addr;
        logic                    we;
        logic [1:0]              be;     // Bit 0 low byte, bit 1 high byte
        logic [15:0]             wdata;
    } mem_req_t;

    // Paired loader bytes, valid for one cycle
    typedef struct packed {
        logic                    valid;
        logic [`BYTE_ADDR_W-1:0] addr;   // Odd byte address of the pair
        logic [15:0]             data;
    } load_wr_t;

    // Console side ROM and work RAM bus, selects and strobes active low
    typedef struct packed {
        logic [`BYTE_ADDR_W-1:0] rom_addr;
        logic                    rom_ce_n;
        logic [`WRAM_ADDR_W-1:0] wram_addr;
        logic                    wram_ce_n;
        logic                    wram_rd_n;
        logic                    wram_we_n;
        logic [7:0]              wram_d;
    } cpu_bus_t;

    // Soft core data port, zero strobes means read
    typedef struct packed {
        logic [`BYTE_ADDR_W-1:0] addr;
        logic [31:0]             wdata;
        logic [3:0]              wstrb;
    } rv_req_t;

endpackage

`default_nettype wire

//--- rtl/snes_mem_top.sv
// Memory front end top. Read latency depends on soft core traffic, so rom_q and wram_q must be waited on
`timescale 1ns/1ps
`default_nettype none

module snes_mem_top
    import snes_mem_pkg::*;
(
    input  logic        mclk,
    input  logic        resetn,
    input  logic        loading,
    input  logic        load_valid,
    input  logic [7:0]  load_data,
    input  cpu_bus_t    cpu_bus,
    input  logic        rv_valid,
    input  rv_req_t     rv_cmd,
    output logic [15:0] rom_q,
    output logic [7:0]  wram_q,
    output logic        rv_ready,
    output logic [31:0] rv_rdata,
    output logic        loaded,
    output logic        enable
);

    load_wr_t    load_wr;
    logic        cpu_req;
    logic        cpu_ack;
    mem_req_t    cpu_cmd;
    logic [15:0] cpu_rdata;
    logic        rv_req;
    logic        rv_ack;
    mem_req_t    rv_mem_cmd;
    logic [15:0] rv_mem_rdata;

    rom_loader i_rom_loader (
        .mclk       (mclk),
        .resetn     (resetn),
        .loading    (loading),
        .load_valid (load_valid),
        .load_data  (load_data),
        .load_wr    (load_wr),
        .loaded     (loaded),
        .enable     (enable)
    );

    // Console and loader share one port
    cpu_port_req i_cpu_port_req (
        .mclk      (mclk),
        .resetn    (resetn),
        .loading   (loading),
        .load_wr   (load_wr),
        .cpu_bus   (cpu_bus),
        .mem_ack   (cpu_ack),
        .mem_rdata (cpu_rdata),
        .mem_req   (cpu_req),
        .mem_cmd   (cpu_cmd),
        .rom_q     (rom_q),
        .wram_q    (wram_q)
    );

    rv_bridge i_rv_bridge (
        .mclk      (mclk),
        .resetn    (resetn),
        .rv_valid  (rv_valid),
        .rv_cmd    (rv_cmd),
        .mem_ack   (rv_ack),
        .mem_rdata (rv_mem_rdata),
        .rv_ready  (rv_ready),
        .rv_rdata  (rv_rdata),
        .mem_req   (rv_req),
        .mem_cmd   (rv_mem_cmd)
    );

    word_mem i_word_mem (
        .mclk      (mclk),
        .resetn    (resetn),
        .cpu_req   (cpu_req),
        .cpu_cmd   (cpu_cmd),
        .rv_req    (rv_req),
        .rv_cmd    (rv_mem_cmd),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .rv_ack    (rv_ack),
        .rv_rdata  (rv_mem_rdata)
    );

endmodule

`default_nettype wire

//--- rtl/word_mem.sv
// Block RAM stand-in for the SDRAM. No refresh or busy, console port always wins a conflict
`timescale 1ns/1ps
`default_nettype none

`include "snes_mem_consts.svh"

module word_mem
    import snes_mem_pkg::*;
(
    input  logic        mclk,
    input  logic        resetn,
    input  logic        cpu_req,
    input  mem_req_t    cpu_cmd,
    input  logic        rv_req,
    input  mem_req_t    rv_cmd,
    output logic        cpu_ack,
    output logic [15:0] cpu_rdata,
    output logic        rv_ack,
    output logic [15:0] rv_rdata
);

    localparam int DEPTH = 1 << `WORD_ADDR_W;

    logic [15:0] mem [DEPTH];
    logic        cpu_pend;
    logic        rv_pend;
    logic        go;
    logic        sel_rv;
    mem_req_t    cmd;

    assign cpu_pend = cpu_req != cpu_ack;
    assign rv_pend  = rv_req != rv_ack;
    assign go       = cpu_pend | rv_pend;
    assign sel_rv   = ~cpu_pend;
    assign cmd      = sel_rv ? rv_cmd : cpu_cmd;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            cpu_ack <= 1'b0;
            rv_ack  <= 1'b0;
        end else if (cpu_pend) begin
            cpu_ack <= cpu_req;
        end else if (rv_pend) begin
            rv_ack <= rv_req;
        end
    end

    // Byte lane writes, read data kept per port
    always_ff @(posedge mclk) begin
        if (go && cmd.we) begin
            if (cmd.be[0])
                mem[cmd.addr][7:0] <= cmd.wdata[7:0];
            if (cmd.be[1])
                mem[cmd.addr][15:8] <= cmd.wdata[15:8];
        end
        if (go && !cmd.we) begin
            if (sel_rv)
                rv_rdata <= mem[cmd.addr];
            else
                cpu_rdata <= mem[cmd.addr];
        end
    end

    a_cpu_ack: assert property (@(posedge mclk) disable iff (!resetn)
        !cpu_pend |=> $stable(cpu_ack));
    a_rv_ack: assert property (@(posedge mclk) disable iff (!resetn)
        !rv_pend |=> $stable(rv_ack));

endmodule

`default_nettype wire

//--- snes_mem.f
+incdir+rtl
rtl/snes_mem_pkg.sv
rtl/rom_loader.sv
rtl/cpu_port_req.sv
rtl/rv_bridge.sv
rtl/word_mem.sv
rtl/snes_mem_top.sv
dv/tb_clock.sv
dv/snes_mem_tb.sv
